// File: hdl/keypad_display_pkg.sv
`default_nettype none

package keypad_display_pkg;

    localparam int KEY_W     = 12;
    localparam int DIGITS    = 8;
    localparam int POS_W     = 3;
    localparam int SEG_W     = 7;
    localparam int SCAN_HOLD = 4;
    localparam int HOLD_W    = $clog2(SCAN_HOLD);

    localparam int KEY_ZERO  = 9;   // bits below this are digits 1..9
    localparam int KEY_SHOW  = 10;
    localparam int KEY_NEXT  = 11;

    typedef enum logic [1:0] {
        OP_DIGIT,
        OP_NEXT,
        OP_SHOW
    } key_op_t;

    typedef struct packed {
        key_op_t    op;
        logic [3:0] value;   // only meaningful for OP_DIGIT
    } key_event_t;

    typedef struct packed {
        logic [DIGITS-1:0][SEG_W-1:0] slot;   // indexed by entry position
    } seg_bank_t;

    typedef enum logic {
        ST_IDLE,
        ST_APPLY
    } ctrl_state_t;

    // abcdefg, segment a in the msb
    function automatic logic [SEG_W-1:0] digit_segments(input logic [3:0] value);
        logic [SEG_W-1:0] seg;
        case (value)
            4'd0:    seg = 7'b1111110;
            4'd1:    seg = 7'b0110000;
            4'd2:    seg = 7'b1101101;
            4'd3:    seg = 7'b1111001;
            4'd4:    seg = 7'b0110011;
            4'd5:    seg = 7'b1011011;
            4'd6:    seg = 7'b1011111;
            4'd7:    seg = 7'b1110010;
            4'd8:    seg = 7'b1111111;
            4'd9:    seg = 7'b1111011;
            default: seg = '0;   // blank
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

// File: hdl/key_capture.sv
`default_nettype none

module key_capture (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [keypad_display_pkg::KEY_W-1:0] keypad,
    output logic                                 key_valid,
    output keypad_display_pkg::key_event_t       key_event,
    input  logic                                 key_ready
);

    import keypad_display_pkg::*;

    logic [KEY_W-1:0] keypad_prev;
    logic             one_hot;
    logic             fresh;
    logic             pending;
    logic             load;
    key_event_t       dec_event;

    // exactly one key down, nothing down on the sample before
    assign one_hot = (keypad != '0) && ((keypad & (keypad - 1'b1)) == '0);
    assign fresh   = one_hot && (keypad_prev == '0);
    assign pending = key_valid && !key_ready;
    assign load    = fresh && !pending;   // press while busy is dropped

    always_comb begin
        dec_event.op    = OP_DIGIT;
        dec_event.value = 4'd0;   // bit 9 falls through as digit 0
        for (int k = 0; k < KEY_ZERO; k++) begin
            if (keypad[k]) begin
                dec_event.value = 4'(k + 1);
            end
        end
        if (keypad[KEY_SHOW]) begin
            dec_event.op = OP_SHOW;
        end
        if (keypad[KEY_NEXT]) begin
            dec_event.op = OP_NEXT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            keypad_prev <= '0;
            key_valid   <= 1'b0;
        end else begin
            keypad_prev <= keypad;
            if (load) begin
                key_valid <= 1'b1;
            end else if (key_ready) begin
                key_valid <= 1'b0;   // handshake done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            key_event <= dec_event;
        end
    end

endmodule

`default_nettype wire

// File: hdl/entry_control.sv
`default_nettype none

module entry_control (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 key_valid,
    input  keypad_display_pkg::key_event_t       key_event,
    output logic                                 key_ready,
    output logic                                 wr_en,
    output logic [keypad_display_pkg::POS_W-1:0] wr_pos,
    output logic [keypad_display_pkg::SEG_W-1:0] wr_seg,
    output logic                                 show_en,
    output logic [keypad_display_pkg::POS_W-1:0] entry_pos,
    output logic                                 shown_update
);

    import keypad_display_pkg::*;

    ctrl_state_t state;
    key_event_t  event_q;
    logic        accept;
    logic        applying;

    assign accept   = key_valid && key_ready;
    assign applying = (state == ST_APPLY);

    // ready drops for the single apply cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= ST_IDLE;
            key_ready <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state     <= ST_APPLY;
                        key_ready <= 1'b0;
                    end else begin
                        key_ready <= 1'b1;
                    end
                end
                ST_APPLY: begin
                    state     <= ST_IDLE;
                    key_ready <= 1'b1;
                end
                default: begin
                    state     <= ST_IDLE;
                    key_ready <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            event_q <= key_event;
        end
    end

    // store commands, valid only in apply
    assign wr_en   = applying && (event_q.op == OP_DIGIT);
    assign wr_pos  = entry_pos;
    assign wr_seg  = digit_segments(event_q.value);
    assign show_en = applying && (event_q.op == OP_SHOW);

    always_ff @(posedge clk) begin
        if (!rst) begin
            entry_pos    <= '0;
            shown_update <= 1'b0;
        end else begin
            shown_update <= show_en;
            if (applying && (event_q.op == OP_NEXT)) begin
                entry_pos <= entry_pos + 1'b1;   // wraps 7 -> 0
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/digit_store.sv
`default_nettype none

module digit_store (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 wr_en,
    input  logic [keypad_display_pkg::POS_W-1:0] wr_pos,
    input  logic [keypad_display_pkg::SEG_W-1:0] wr_seg,
    input  logic                                 show_en,
    output keypad_display_pkg::seg_bank_t        shown
);

    import keypad_display_pkg::*;

    seg_bank_t working;   // bank being edited

    always_ff @(posedge clk) begin
        if (!rst) begin
            working <= '0;
        end else if (wr_en) begin
            working.slot[wr_pos] <= wr_seg;
        end
    end

    // whole bank moves at once so the display never shows half an edit
    always_ff @(posedge clk) begin
        if (!rst) begin
            shown <= '0;
        end else if (show_en) begin
            shown <= working;
        end
    end

endmodule

`default_nettype wire

// File: hdl/segment_scanner.sv
`default_nettype none

module segment_scanner (
    input  logic                                  clk,
    input  logic                                  rst,
    input  keypad_display_pkg::seg_bank_t         shown,
    output logic [keypad_display_pkg::SEG_W-1:0]  seg_data,
    output logic [keypad_display_pkg::DIGITS-1:0] digit_en
);

    import keypad_display_pkg::*;

    logic [HOLD_W-1:0] hold_cnt;
    logic [POS_W-1:0]  scan_pos;
    logic              hold_done;

    assign hold_done = (hold_cnt == HOLD_W'(SCAN_HOLD - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            hold_cnt <= '0;
            scan_pos <= '0;
        end else if (hold_done) begin
            hold_cnt <= '0;
            scan_pos <= scan_pos + 1'b1;   // 8 digits, wraps naturally
        end else begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_comb begin
        digit_en           = '0;
        digit_en[scan_pos] = 1'b1;
    end

    // same-cycle select, no pipeline between enable and data
    assign seg_data = shown.slot[scan_pos];

endmodule

`default_nettype wire

// File: hdl/keypad_display_top.sv
`default_nettype none

module keypad_display_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [keypad_display_pkg::KEY_W-1:0]  keypad,
    output logic [keypad_display_pkg::SEG_W-1:0]  seg_data,
    output logic [keypad_display_pkg::DIGITS-1:0] digit_en,
    output logic [keypad_display_pkg::POS_W-1:0]  entry_pos,
    output logic                                  shown_update
);

    import keypad_display_pkg::*;

    logic             key_valid;
    logic             key_ready;
    key_event_t       key_event;
    logic             wr_en;
    logic [POS_W-1:0] wr_pos;
    logic [SEG_W-1:0] wr_seg;
    logic             show_en;
    seg_bank_t        shown;

    key_capture u_key_capture (
        .clk       (clk),
        .rst       (rst),
        .keypad    (keypad),
        .key_valid (key_valid),
        .key_event (key_event),
        .key_ready (key_ready)
    );

    entry_control u_entry_control (
        .clk          (clk),
        .rst          (rst),
        .key_valid    (key_valid),
        .key_event    (key_event),
        .key_ready    (key_ready),
        .wr_en        (wr_en),
        .wr_pos       (wr_pos),
        .wr_seg       (wr_seg),
        .show_en      (show_en),
        .entry_pos    (entry_pos),
        .shown_update (shown_update)
    );

    digit_store u_digit_store (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_pos  (wr_pos),
        .wr_seg  (wr_seg),
        .show_en (show_en),
        .shown   (shown)
    );

    segment_scanner u_segment_scanner (
        .clk      (clk),
        .rst      (rst),
        .shown    (shown),
        .seg_data (seg_data),
        .digit_en (digit_en)
    );

endmodule

`default_nettype wire

// File: verification/keypad_display_tb.sv
`default_nettype none

module keypad_display_tb;

    import keypad_display_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int SETTLE       = 2;   // sampled press to bank update
    localparam int SCAN_CYCLES  = 8 * SCAN_HOLD * DIGITS;
    localparam logic [3:0] BLANK = 4'hf;

    typedef struct packed {
        logic                   is_expect;
        logic [KEY_W-1:0]       pattern;
        logic [15:0]            hold;
        logic [15:0]            rel_cycles;
        logic [DIGITS-1:0][3:0] digits;   // blank as f
    } step_t;

    typedef struct packed {
        logic       valid;
        key_op_t    op;
        logic [3:0] value;
    } model_event_t;

    logic              clk;
    logic              rst;
    logic [KEY_W-1:0]  keypad;
    logic [SEG_W-1:0]  seg_data;
    logic [DIGITS-1:0] digit_en;
    logic [POS_W-1:0]  entry_pos;
    logic              shown_update;

    step_t steps[$];
    int    budget;
    logic  budget_ready;

    logic [KEY_W-1:0]       prev_pat;
    model_event_t           stage_sampled;    // seen at the last edge
    model_event_t           stage_accepted;   // applies at the next edge
    logic [DIGITS-1:0][3:0] work_digits;
    logic [DIGITS-1:0][3:0] shown_digits;
    logic [POS_W-1:0]       model_pos;
    logic                   exp_update;
    int                     scan_cnt;         // edges since reset release

    keypad_display_top DUT (
        .clk          (clk),
        .rst          (rst),
        .keypad       (keypad),
        .seg_data     (seg_data),
        .digit_en     (digit_en),
        .entry_pos    (entry_pos),
        .shown_update (shown_update)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // abcdefg order with a in the msb
    function automatic logic [SEG_W-1:0] pattern_of(input logic [3:0] digit);
        case (digit)
            4'd0:    return 7'b1111110;
            4'd1:    return 7'b0110000;
            4'd2:    return 7'b1101101;
            4'd3:    return 7'b1111001;
            4'd4:    return 7'b0110011;
            4'd5:    return 7'b1011011;
            4'd6:    return 7'b1011111;
            4'd7:    return 7'b1110010;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1111011;
            default: return '0;
        endcase
    endfunction

    function automatic model_event_t decode_press(input logic [KEY_W-1:0] pat,
                                                  input logic [KEY_W-1:0] prev);
        model_event_t ev;
        ev.valid = ($countones(pat) == 1) && (prev == '0);
        ev.op    = OP_DIGIT;
        ev.value = 4'd0;   // bit 9 is digit 0
        if (pat[11]) begin
            ev.op = OP_NEXT;
        end else if (pat[10]) begin
            ev.op = OP_SHOW;
        end else begin
            for (int k = 0; k < 9; k++) begin
                if (pat[k]) begin
                    ev.value = 4'(k + 1);
                end
            end
        end
        return ev;
    endfunction

    task automatic end_with_failure();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("Fail at time %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic reset_model();
        prev_pat       = '0;
        stage_sampled  = '0;
        stage_accepted = '0;
        work_digits    = '1;   // all blank
        shown_digits   = '1;
        model_pos      = '0;
        exp_update     = 1'b0;
        scan_cnt       = 0;
    endtask

    task automatic apply_event(input model_event_t ev);
        case (ev.op)
            OP_DIGIT: work_digits[model_pos] = ev.value;
            OP_NEXT:  model_pos = model_pos + 1'b1;
            OP_SHOW: begin
                shown_digits = work_digits;
                exp_update   = 1'b1;
            end
            default: ;
        endcase
    endtask

    // what the design does at one rising edge
    task automatic advance_model(input logic [KEY_W-1:0] pat);
        exp_update = 1'b0;
        if (stage_accepted.valid) begin
            apply_event(stage_accepted);
        end
        stage_accepted = stage_sampled;
        stage_sampled  = decode_press(pat, prev_pat);
        prev_pat       = pat;
        scan_cnt++;
    endtask

    task automatic check_outputs();
        int                pos;
        logic [DIGITS-1:0] exp_en;
        pos         = (scan_cnt / SCAN_HOLD) % DIGITS;
        exp_en      = '0;
        exp_en[pos] = 1'b1;
        check_value("digit_en bits set", 1, $countones(digit_en));
        check_value("digit_en", exp_en, digit_en);
        check_value("seg_data", pattern_of(shown_digits[pos]), seg_data);
        check_value("entry_pos", model_pos, entry_pos);
        check_value("shown_update", exp_update, shown_update);
    endtask

    // entered and left at a falling edge
    task automatic run_cycle(input logic [KEY_W-1:0] pat);
        keypad = pat;
        @(posedge clk);
        advance_model(pat);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic check_expect(input logic [DIGITS-1:0][3:0] digits);
        int pos;
        repeat (SETTLE) run_cycle('0);
        check_value("shown bank of model vs file", digits, shown_digits);
        repeat (SCAN_CYCLES) begin
            run_cycle('0);
            pos = (scan_cnt / SCAN_HOLD) % DIGITS;
            check_value("seg_data vs file", pattern_of(digits[pos]), seg_data);
        end
    endtask

    task automatic load_stimulus();
        int               fd;
        int               code;
        int               hold;
        int               rel;
        int               i;
        byte              c;
        string            tag;
        string            text;
        logic [KEY_W-1:0] pat;
        step_t            step;
        fd = $fopen("verification/keypad_display_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            end_with_failure();
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            step = '0;
            if (tag.substr(0, 0) == "#") begin
                code = $fgets(text, fd);   // rest of a comment line
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %d %d", pat, hold, rel);
                if (code != 3 || hold < 1 || rel < 1) begin
                    $display("Malformed press line in the stimulus file");
                    end_with_failure();
                end
                step.pattern    = pat;
                step.hold       = 16'(hold);
                step.rel_cycles = 16'(rel);
                steps.push_back(step);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%s", text);
                if (code != 1 || text.len() != DIGITS) begin
                    $display("Malformed expect line in the stimulus file");
                    end_with_failure();
                end
                step.is_expect = 1'b1;
                for (i = 0; i < DIGITS; i++) begin
                    c = text[i];
                    if (c == "-") begin
                        step.digits[i] = BLANK;
                    end else if (c >= "0" && c <= "9") begin
                        step.digits[i] = 4'(c - "0");
                    end else begin
                        $display("Bad digit character in an expect line");
                        end_with_failure();
                    end
                end
                steps.push_back(step);
            end else begin
                $display("Unknown line kind %s in the stimulus file", tag);
                end_with_failure();
            end
        end
        $fclose(fd);
    endtask

    function automatic int stimulus_budget();
        int total;
        total = RESET_CYCLES + SETTLE + 200;
        foreach (steps[n]) begin
            if (steps[n].is_expect) begin
                total += SETTLE + SCAN_CYCLES;
            end else begin
                total += steps[n].hold + steps[n].rel_cycles + 3;   // worst random gap
            end
        end
        return total;
    endfunction

    initial begin
        wait (budget_ready === 1'b1);
        repeat (budget) @(posedge clk);
        $display("Timeout: the run was still going after %0d clock cycles", budget);
        end_with_failure();
    end

    initial begin
        int extra;
        keypad       = '0;
        rst          = 1'b0;
        budget_ready = 1'b0;
        void'($urandom(32'hb6f5));
        reset_model();
        load_stimulus();
        budget       = stimulus_budget();
        budget_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value("entry_pos", 0, entry_pos);
        check_value("shown_update", 0, shown_update);
        check_value("digit_en", 1, digit_en);
        check_value("seg_data", 0, seg_data);
        rst = 1'b1;
        repeat (SETTLE) run_cycle('0);

        foreach (steps[n]) begin
            if (steps[n].is_expect) begin
                check_expect(steps[n].digits);
            end else begin
                repeat (steps[n].hold) run_cycle(steps[n].pattern);
                extra = $urandom_range(3, 0);
                repeat (steps[n].rel_cycles + extra) run_cycle('0);
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: keypad_display.f
hdl/keypad_display_pkg.sv
hdl/key_capture.sv
hdl/entry_control.sv
hdl/digit_store.sv
hdl/segment_scanner.sv
hdl/keypad_display_top.sv
verification/keypad_display_tb.sv

// File: verification/keypad_display_stimulus.txt
# P <keypad hex> <hold cycles> <release cycles>
# E <expected shown digits from position 0 up, - for blank>
E --------
P 001 1 1
P 800 1 1
P 002 2 1
P 800 1 2
P 004 1 1
# entered but not shown yet
E --------
P 400 1 1
E 123-----
P 800 1 1
P 008 1 1
P 800 1 1
P 010 1 1
P 800 1 1
P 020 1 1
P 800 1 1
P 040 1 1
P 800 1 1
P 080 3 1
P 400 1 1
E 12345678
# next from position 7 wraps to 0
P 800 1 1
P 200 1 1
P 400 1 1
E 02345678
# nine next presses, 0 back round to 1
P 800 1 1
P 800 1 1
P 800 1 1
P 800 2 1
P 800 1 1
P 800 1 1
P 800 1 3
P 800 1 1
P 800 1 1
P 100 1 1
P 400 1 1
E 09345678
# two keys at once
P 003 1 1
P 801 2 1
P c00 1 1
# held key counts once
P 020 20 1
P 400 1 1
E 06345678
P 010 1 1
E 06345678
P 400 1 1
E 05345678
